/* hw/udp_hdr_pkg.sv */
package udp_hdr_pkg;

    typedef logic [15:0] udp_port_t;

    // Octet 3 is the first octet on the wire
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] octet;
    } ipv4_addr_u;

    // 136 bits per header
    typedef struct packed {
        ipv4_addr_u  src_ip;
        ipv4_addr_u  dst_ip;
        udp_port_t   src_port;
        udp_port_t   dst_port;
        logic [15:0] length;
        logic [15:0] checksum;
        logic [7:0]  ttl;
    } udp_hdr_t;

    // Dotted-quad notation, e.g. a.b.c.d
    function automatic ipv4_addr_u ipv4_from_octets(
        input logic [7:0] a,
        input logic [7:0] b,
        input logic [7:0] c,
        input logic [7:0] d
    );
        ipv4_addr_u addr;
        addr.octet[3] = a;
        addr.octet[2] = b;
        addr.octet[1] = c;
        addr.octet[0] = d;
        return addr;
    endfunction

endpackage

/* hw/stream_pkg.sv */
package stream_pkg;

    parameter int DATA_W = 64;
    parameter int KEEP_W = DATA_W / 8;

    // One payload beat with one keep bit per data byte
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        logic              user;
    } pay_beat_t;

endpackage

/* hw/udp_echo_ctrl.sv */
`timescale 1ns/10ps

module udp_echo_ctrl #(
    parameter udp_hdr_pkg::udp_port_t ECHO_PORT = 16'd1234
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   in_hdr_valid,
    input  udp_hdr_pkg::udp_port_t in_dst_port,
    output logic                   in_hdr_ready,

    input  logic                   in_pay_valid,
    input  logic                   in_pay_last,
    output logic                   in_pay_ready,

    input  logic                   hdr_busy,
    output logic                   hdr_load,

    input  logic                   fifo_full,
    output logic                   fifo_wr,

    input  logic [7:0]             out_first_byte,
    input  logic                   out_pay_valid,
    input  logic                   out_pay_last,
    input  logic                   out_pay_ready,
    output logic [7:0]             led
);

    logic frame_open;
    logic echo_frame;
    logic out_first;
    logic [7:0] led_q;

    logic is_echo;
    logic hdr_xfer;
    logic pay_xfer;
    logic out_xfer;

    assign is_echo = (in_dst_port == ECHO_PORT);

    // New header only between frames and once the reply slot is free
    assign in_hdr_ready = !frame_open && !hdr_busy;
    assign hdr_xfer     = in_hdr_valid && in_hdr_ready;
    assign hdr_load     = hdr_xfer && is_echo;

    // Drop frames are always drained, echo frames wait on FIFO space
    assign in_pay_ready = frame_open && (echo_frame ? !fifo_full : 1'b1);
    assign pay_xfer     = in_pay_valid && in_pay_ready;
    assign fifo_wr      = pay_xfer && echo_frame;

    assign out_xfer = out_pay_valid && out_pay_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_open <= 1'b0;
            echo_frame <= 1'b0;
        end else begin
            if (hdr_xfer) begin
                frame_open <= 1'b1;
                echo_frame <= is_echo;
            end else if (pay_xfer && in_pay_last) begin
                frame_open <= 1'b0;
            end
        end
    end

    // First output beat of each echoed frame goes to the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            out_first <= 1'b1;
            led_q     <= 8'd0;
        end else if (out_xfer) begin
            if (out_first) begin
                led_q <= out_first_byte;
            end
            out_first <= out_pay_last;
        end
    end

    assign led = led_q;

endmodule

/* hw/udp_reply_hdr.sv */
`timescale 1ns/10ps

module udp_reply_hdr #(
    parameter udp_hdr_pkg::ipv4_addr_u LOCAL_IP  = '0,
    parameter logic [7:0]              REPLY_TTL = 8'd64
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  hdr_load,
    input  udp_hdr_pkg::udp_hdr_t in_hdr,
    output logic                  hdr_busy,

    output logic                  out_hdr_valid,
    output udp_hdr_pkg::udp_hdr_t out_hdr,
    input  logic                  out_hdr_ready
);

    logic                  valid_q;
    udp_hdr_pkg::udp_hdr_t hdr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (hdr_load) begin
            valid_q <= 1'b1;
        end else if (valid_q && out_hdr_ready) begin
            valid_q <= 1'b0;
        end
    end

    // Reply goes back to the sender with ports swapped
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            hdr_q.src_ip.word <= LOCAL_IP.word;
            hdr_q.dst_ip.word <= in_hdr.src_ip.word;
            hdr_q.src_port    <= in_hdr.dst_port;
            hdr_q.dst_port    <= in_hdr.src_port;
            hdr_q.length      <= in_hdr.length;
            hdr_q.checksum    <= 16'd0;
            hdr_q.ttl         <= REPLY_TTL;
        end
    end

    assign out_hdr_valid = valid_q;
    assign out_hdr       = hdr_q;
    assign hdr_busy      = valid_q;

endmodule

/* hw/udp_payload_fifo.sv */
`timescale 1ns/10ps

module udp_payload_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  wr,
    input  stream_pkg::pay_beat_t wr_beat,
    output logic                  full,

    output logic                  rd_valid,
    output stream_pkg::pay_beat_t rd_beat,
    input  logic                  rd_ready
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    stream_pkg::pay_beat_t mem [DEPTH];

    // Extra pointer bit tells full from empty
    logic [FIFO_DEPTH_LOG2:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2:0] rd_ptr;

    logic empty;
    logic wr_en;
    logic rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
                   (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);

    assign wr_en = wr && !full;
    assign rd_en = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Oldest beat is always on the read port
    assign rd_valid = !empty;
    assign rd_beat  = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

endmodule

/* hw/udp_echo_top.sv */
`timescale 1ns/10ps

module udp_echo_top #(
    parameter udp_hdr_pkg::udp_port_t  ECHO_PORT       = 16'd1234,
    parameter udp_hdr_pkg::ipv4_addr_u LOCAL_IP        =
        udp_hdr_pkg::ipv4_from_octets(8'd192, 8'd168, 8'd1, 8'd128),
    parameter logic [7:0]              REPLY_TTL       = 8'd64,
    parameter int                      FIFO_DEPTH_LOG2 = 4
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in_hdr_valid,
    input  udp_hdr_pkg::udp_hdr_t in_hdr,
    output logic                  in_hdr_ready,

    input  logic                  in_pay_valid,
    input  stream_pkg::pay_beat_t in_pay,
    output logic                  in_pay_ready,

    output logic                  out_hdr_valid,
    output udp_hdr_pkg::udp_hdr_t out_hdr,
    input  logic                  out_hdr_ready,

    output logic                  out_pay_valid,
    output stream_pkg::pay_beat_t out_pay,
    input  logic                  out_pay_ready,

    output logic [7:0]            led
);

    logic hdr_load;
    logic hdr_busy;
    logic fifo_full;
    logic fifo_wr;

    udp_echo_ctrl #(
        .ECHO_PORT(ECHO_PORT)
    ) udp_echo_ctrl_inst (
        .clk(clk),
        .rst(rst),
        .in_hdr_valid(in_hdr_valid),
        .in_dst_port(in_hdr.dst_port),
        .in_hdr_ready(in_hdr_ready),
        .in_pay_valid(in_pay_valid),
        .in_pay_last(in_pay.last),
        .in_pay_ready(in_pay_ready),
        .hdr_busy(hdr_busy),
        .hdr_load(hdr_load),
        .fifo_full(fifo_full),
        .fifo_wr(fifo_wr),
        .out_first_byte(out_pay.data[7:0]),
        .out_pay_valid(out_pay_valid),
        .out_pay_last(out_pay.last),
        .out_pay_ready(out_pay_ready),
        .led(led)
    );

    udp_reply_hdr #(
        .LOCAL_IP(LOCAL_IP),
        .REPLY_TTL(REPLY_TTL)
    ) udp_reply_hdr_inst (
        .clk(clk),
        .rst(rst),
        .hdr_load(hdr_load),
        .in_hdr(in_hdr),
        .hdr_busy(hdr_busy),
        .out_hdr_valid(out_hdr_valid),
        .out_hdr(out_hdr),
        .out_hdr_ready(out_hdr_ready)
    );

    udp_payload_fifo #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) udp_payload_fifo_inst (
        .clk(clk),
        .rst(rst),
        .wr(fifo_wr),
        .wr_beat(in_pay),
        .full(fifo_full),
        .rd_valid(out_pay_valid),
        .rd_beat(out_pay),
        .rd_ready(out_pay_ready)
    );

endmodule

/* verif/udp_echo_tb.sv */
`timescale 1ns/10ps

module udp_echo_tb;

    localparam logic [15:0] ECHO_PORT = 16'd1234;
    localparam logic [15:0] OTHER_PORT = 16'd5555;
    localparam logic [31:0] LOCAL_IP = 32'hc0a8_0180;
    localparam logic [31:0] SEED = 32'h71684e71;
    // Beats per test in order echo, drop, back-pressure, FIFO full and LED
    localparam int TOTAL_BEATS = 6 + 9 + 30 + 20 + 10;
    // Generous allowance per beat for random stalls on both output channels
    localparam int WATCHDOG_NS = (TOTAL_BEATS * 20 + 400) * 10;

    logic clk = 1'b0;
    logic rst;
    logic in_hdr_valid, in_hdr_ready, in_pay_valid, in_pay_ready;
    logic out_hdr_valid, out_hdr_ready, out_pay_valid, out_pay_ready;
    udp_hdr_pkg::udp_hdr_t in_hdr, out_hdr;
    stream_pkg::pay_beat_t in_pay, out_pay, mon_beat;
    logic [7:0] led;

    udp_hdr_pkg::udp_hdr_t exp_hdr_q[$];
    stream_pkg::pay_beat_t exp_beat_q[$];
    logic [31:0] data_rng = SEED;
    logic [31:0] ready_rng = SEED;
    int ready_mode = 0;
    int beats_acc = 0;
    logic [7:0] exp_led = 8'd0;
    logic out_first = 1'b1;
    logic hdr_follow = 1'b0;

    udp_echo_top udp_echo_top_inst (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [255:0] got, input logic [255:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] time %0t: %s, got %0h expected %0h",
                               $time, what, got, exp));
        end
    endtask

    // Mode 0 all ready, 1 random ready, 2 payload output stalled
    always @(posedge clk) begin
        if (ready_mode == 1) begin
            ready_rng = xorshift32(ready_rng);
            out_hdr_ready <= ready_rng[3];
            out_pay_ready <= ready_rng[11];
        end else begin
            out_hdr_ready <= 1'b1;
            out_pay_ready <= (ready_mode == 0);
        end
    end

    // Scoreboard on the output side, plus LED and header latency model
    always @(posedge clk) begin
        if (!rst) begin
            check("led", led, exp_led);
            if (hdr_follow) begin
                check("out_hdr_valid one cycle after echo header", out_hdr_valid, 1'b1);
            end
            hdr_follow = in_hdr_valid && in_hdr_ready && (in_hdr.dst_port == ECHO_PORT);
            if (out_hdr_valid && out_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    fail_run("A reply header came out when none was expected");
                end else begin
                    check("reply header", out_hdr, exp_hdr_q.pop_front());
                end
            end
            if (out_pay_valid && out_pay_ready) begin
                if (exp_beat_q.size() == 0) begin
                    fail_run("A payload beat came out when none was expected");
                end else begin
                    mon_beat = exp_beat_q.pop_front();
                    check("payload beat", out_pay, mon_beat);
                    if (out_first) begin
                        exp_led = mon_beat.data[7:0];
                    end
                    out_first = mon_beat.last;
                end
            end
        end
    end

    task automatic send_frame(input logic [15:0] dst_port, input int n_beats,
                              input logic [7:0] first_byte);
        udp_hdr_pkg::udp_hdr_t sent;
        udp_hdr_pkg::udp_hdr_t reply;
        stream_pkg::pay_beat_t beats[$];
        stream_pkg::pay_beat_t b;
        data_rng = xorshift32(data_rng);
        sent.src_ip.word = data_rng;
        sent.dst_ip.word = LOCAL_IP;
        data_rng = xorshift32(data_rng);
        sent.src_port = data_rng[15:0];
        sent.dst_port = dst_port;
        sent.length = 16'(8 + 8 * n_beats);
        sent.checksum = data_rng[31:16];
        sent.ttl = 8'd17;
        for (int i = 0; i < n_beats; i++) begin
            data_rng = xorshift32(data_rng);
            b.data[63:32] = data_rng;
            data_rng = xorshift32(data_rng);
            b.data[31:0] = data_rng;
            if (i == 0) begin
                b.data[7:0] = first_byte;
            end
            b.keep = (i == n_beats - 1) ? 8'h0f : 8'hff;
            b.last = (i == n_beats - 1);
            b.user = data_rng[9];
            beats.push_back(b);
        end
        // Reply goes back to the sender with ports swapped
        if (dst_port == ECHO_PORT) begin
            reply.src_ip.word = LOCAL_IP;
            reply.dst_ip.word = sent.src_ip.word;
            reply.src_port = sent.dst_port;
            reply.dst_port = sent.src_port;
            reply.length = sent.length;
            reply.checksum = 16'd0;
            reply.ttl = 8'd64;
            exp_hdr_q.push_back(reply);
            foreach (beats[i]) exp_beat_q.push_back(beats[i]);
        end
        @(posedge clk);
        in_hdr_valid <= 1'b1;
        in_hdr <= sent;
        do @(posedge clk); while (!in_hdr_ready);
        in_hdr_valid <= 1'b0;
        foreach (beats[i]) begin
            in_pay_valid <= 1'b1;
            in_pay <= beats[i];
            do @(posedge clk); while (!in_pay_ready);
            beats_acc++;
        end
        in_pay_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic test_reset_state();
        @(posedge clk);
        check("in_hdr_ready after reset", in_hdr_ready, 1'b1);
        check("in_pay_ready after reset", in_pay_ready, 1'b0);
        check("out_hdr_valid after reset", out_hdr_valid, 1'b0);
        check("out_pay_valid after reset", out_pay_valid, 1'b0);
        check("led after reset", led, 8'd0);
    endtask

    task automatic test_echo();
        send_frame(ECHO_PORT, 6, 8'ha5);
        wait_drain();
    endtask

    task automatic test_drop();
        send_frame(OTHER_PORT, 5, 8'h11);
        repeat (10) @(posedge clk);
        check("out_hdr_valid after drop", out_hdr_valid, 1'b0);
        check("out_pay_valid after drop", out_pay_valid, 1'b0);
        send_frame(ECHO_PORT, 4, 8'h22);
        wait_drain();
    endtask

    task automatic test_back_pressure();
        ready_mode <= 1;
        repeat (5) send_frame(ECHO_PORT, 6, data_rng[23:16]);
        wait_drain();
        ready_mode <= 0;
    endtask

    task automatic test_fifo_full();
        ready_mode <= 2;
        beats_acc = 0;
        fork
            send_frame(ECHO_PORT, 20, 8'h77);
        join_none
        while (beats_acc < 16) @(posedge clk);
        repeat (4) @(posedge clk);
        check("in_pay_ready with FIFO full", in_pay_ready, 1'b0);
        check("beats accepted before stall", beats_acc, 16);
        ready_mode <= 0;
        wait_drain();
    endtask

    task automatic test_led();
        send_frame(ECHO_PORT, 3, 8'h5a);
        wait_drain();
        check("led after echo", led, 8'h5a);
        send_frame(OTHER_PORT, 4, 8'hc3);
        repeat (5) @(posedge clk);
        check("led after drop", led, 8'h5a);
        send_frame(ECHO_PORT, 3, 8'h3c);
        wait_drain();
        check("led after second echo", led, 8'h3c);
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_run("Timeout: the DUT did not finish all frames in time");
    end

    initial begin
        rst = 1'b1;
        in_hdr_valid = 1'b0;
        in_hdr = '0;
        in_pay_valid = 1'b0;
        in_pay = '0;
        out_hdr_ready = 1'b0;
        out_pay_ready = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_echo();
        test_drop();
        test_back_pressure();
        test_fifo_full();
        test_led();
        $display("all tests passed");
        $finish;
    end

endmodule

/* tb.f */
hw/udp_hdr_pkg.sv
hw/stream_pkg.sv
hw/udp_echo_ctrl.sv
hw/udp_reply_hdr.sv
hw/udp_payload_fifo.sv
hw/udp_echo_top.sv
verif/udp_echo_tb.sv

/* Bender.yml */
package:
  name: udp_echo

sources:
  - files:
      - hw/udp_hdr_pkg.sv
      - hw/stream_pkg.sv
      - hw/udp_echo_ctrl.sv
      - hw/udp_reply_hdr.sv
      - hw/udp_payload_fifo.sv
      - hw/udp_echo_top.sv
  - target: test
    files:
      - verif/udp_echo_tb.sv
